// ==== filelist.f ====
design/agenPkg.sv
design/physRegFile.sv
design/agenStation.sv
design/addressCalc.sv
design/agenTop.sv
verification/agenChecker.sv
verification/agenTb.sv

// ==== Bender.yml ====
package:
  name: agen

sources:
  - files:
      - design/agenPkg.sv
      - design/physRegFile.sv
      - design/agenStation.sv
      - design/addressCalc.sv
      - design/agenTop.sv
  - target: test
    files:
      - verification/agenChecker.sv
      - verification/agenTb.sv

// ==== verification/agenTb.sv ====
`timescale 1ns/1ps

module agenTb;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 16;
	localparam int numOps = 200;
	// Room per operation for two allocations, two delayed writebacks and the request
	localparam int timeoutCycles = numOps * 20 + resetCycles + agenPkg::numPhysRegs;

	logic clk;
	logic rst;
	logic issue;
	agenPkg::memOp_t issueOp;
	logic [agenPkg::robIndexWidth-1:0] issueRobIndex;
	logic [agenPkg::pRegWidth-1:0] issuePRs1;
	logic [agenPkg::pRegWidth-1:0] issuePRs2;
	logic [agenPkg::pRegWidth-1:0] issuePRs3;
	logic [agenPkg::immWidth-1:0] issueImm;
	logic wbValid;
	logic [agenPkg::pRegWidth-1:0] wbReg;
	logic [agenPkg::dataWidth-1:0] wbData;
	logic allocValid;
	logic [agenPkg::pRegWidth-1:0] allocReg;
	logic idle;
	logic reqValid;
	agenPkg::memOp_t reqOp;
	logic [agenPkg::robIndexWidth-1:0] reqRobIndex;
	logic [agenPkg::dataWidth-1:0] reqAddr;
	logic [agenPkg::dataWidth-1:0] reqData;

	// Model state: register values and the requests still owed by the DUT
	logic [agenPkg::dataWidth-1:0] mirror [agenPkg::numPhysRegs];
	logic [31:0] expOp [$];
	logic [31:0] expRob [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	integer seed;
	int valueErrors;
	int otherErrors;
	int assertErrors;
	int pendingWb;
	int issueCount;
	int respCount;

	agenTop agenTop_inst (
		.clk             (clk),
		.rst             (rst),
		.issue_i         (issue),
		.issueOp_i       (issueOp),
		.issueRobIndex_i (issueRobIndex),
		.issuePRs1_i     (issuePRs1),
		.issuePRs2_i     (issuePRs2),
		.issuePRs3_i     (issuePRs3),
		.issueImm_i      (issueImm),
		.wbValid_i       (wbValid),
		.wbReg_i         (wbReg),
		.wbData_i        (wbData),
		.allocValid_i    (allocValid),
		.allocReg_i      (allocReg),
		.idle_o          (idle),
		.reqValid_o      (reqValid),
		.reqOp_o         (reqOp),
		.reqRobIndex_o   (reqRobIndex),
		.reqAddr_o       (reqAddr),
		.reqData_o       (reqData)
	);

	// The checker watches the top-level result and the station state inside it
	bind agenTop agenChecker agenChecker_inst (
		.clk          (clk),
		.rst          (rst),
		.gatherDone_i (gatherDone),
		.reqValid_i   (reqValid_o),
		.idle_i       (idle_o),
		.state_i      (agenStation_inst.state)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// ========================================
	// Model and helpers
	// ========================================

	function automatic int pickBelow(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Register zero reads as zero whatever was last written to it
	function automatic logic [31:0] operandValue(input logic [agenPkg::pRegWidth-1:0] r);
		return (r == 0) ? 32'h0 : mirror[r];
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			valueErrors++;
			$display("ERR %s expected %h got %h", name, expected, actual);
		end
	endtask

	// Each bus task drives at a falling edge and holds for one cycle
	task automatic writeBack(input logic [agenPkg::pRegWidth-1:0] r, input logic [31:0] d);
		wbValid = 1'b1;
		wbReg = r;
		wbData = d;
		mirror[r] = d;
		@(negedge clk);
		wbValid = 1'b0;
	endtask

	task automatic allocate(input logic [agenPkg::pRegWidth-1:0] r);
		allocValid = 1'b1;
		allocReg = r;
		@(negedge clk);
		allocValid = 1'b0;
	endtask

	// Works out the expected request from the model, then issues once idle
	task automatic sendOp(input agenPkg::memOp_t op, input logic [agenPkg::pRegWidth-1:0] rs1,
		input logic [agenPkg::pRegWidth-1:0] rs2, input logic [agenPkg::pRegWidth-1:0] rs3,
		input logic [agenPkg::immWidth-1:0] imm);
		logic [31:0] addr;
		logic [31:0] data;
		addr = operandValue(rs1) + operandValue(rs2)
			+ {{(agenPkg::dataWidth - agenPkg::immWidth){imm[agenPkg::immWidth-1]}}, imm};
		data = 32'h0;
		if (op == agenPkg::MEM_STORE || op == agenPkg::MEM_AMO) begin
			data = operandValue(rs3);
		end
		// A NOP only completes its reorder buffer entry
		if (op == agenPkg::MEM_NOP) begin
			addr = 32'h0;
		end
		while (!idle) @(negedge clk);
		expOp.push_back(op);
		expRob.push_back(issueCount % 32);
		expAddr.push_back(addr);
		expData.push_back(data);
		issue = 1'b1;
		issueOp = op;
		issueRobIndex = issueCount % 32;
		issuePRs1 = rs1;
		issuePRs2 = rs2;
		issuePRs3 = rs3;
		issueImm = imm;
		issueCount++;
		@(negedge clk);
		issue = 1'b0;
		// The capturing edge also takes the station out of idle
		checkValue("idle_o", 0, idle);
	endtask

	// One random operation, with up to two sources renamed and written back late
	task automatic runOperation();
		agenPkg::memOp_t op;
		logic [agenPkg::pRegWidth-1:0] src [3];
		logic [agenPkg::pRegWidth-1:0] lateReg [2];
		logic [31:0] lateData [2];
		logic [agenPkg::pRegWidth-1:0] r;
		int numLate;
		int want;
		int slot;
		op = agenPkg::memOp_t'(pickBelow(4));
		for (int i = 0; i < 3; i++) begin
			src[i] = (pickBelow(8) == 0) ? 0 : pickBelow(agenPkg::numPhysRegs);
		end
		// Non-zero data in register zero must never reach an operand
		if (pickBelow(8) == 0) begin
			writeBack(0, $random(seed) | 1);
		end
		numLate = 0;
		want = pickBelow(3);
		slot = pickBelow(3);
		for (int k = 0; k < want; k++) begin
			r = src[(slot + k) % 3];
			if (r != 0 && !(numLate == 1 && lateReg[0] == r)) begin
				lateReg[numLate] = r;
				lateData[numLate] = $random(seed);
				allocate(r);
				mirror[r] = lateData[numLate];
				numLate++;
			end
		end
		pendingWb = numLate;
		sendOp(op, src[0], src[1], src[2], pickBelow(4096));
		// A zero delay lands the writeback in the first gather cycle, on the bypass lane
		for (int k = 0; k < numLate; k++) begin
			repeat (pickBelow(7)) @(negedge clk);
			pendingWb--;
			writeBack(lateReg[k], lateData[k]);
		end
		while (respCount < issueCount) @(negedge clk);
	endtask

	// ========================================
	// Response monitor
	// ========================================

	always @(negedge clk) begin
		if (!rst && reqValid) begin
			respCount++;
			assert (expAddr.size() > 0) else begin
				otherErrors++;
				$display("A request came out with no instruction outstanding");
			end
			if (expAddr.size() > 0) begin
				assert (pendingWb == 0) else begin
					otherErrors++;
					$display("A request came out before its last source writeback");
				end
				// The station is back in idle by the time the request goes out
				checkValue("idle_o", 1, idle);
				checkValue("reqOp_o", expOp.pop_front(), reqOp);
				checkValue("reqRobIndex_o", expRob.pop_front(), reqRobIndex);
				checkValue("reqAddr_o", expAddr.pop_front(), reqAddr);
				checkValue("reqData_o", expData.pop_front(), reqData);
			end
		end
	end

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		seed = 29;
		valueErrors = 0;
		otherErrors = 0;
		pendingWb = 0;
		issueCount = 0;
		respCount = 0;
		rst = 1'b1;
		issue = 1'b0;
		issueOp = agenPkg::MEM_NOP;
		issueRobIndex = '0;
		issuePRs1 = '0;
		issuePRs2 = '0;
		issuePRs3 = '0;
		issueImm = '0;
		wbValid = 1'b0;
		wbReg = '0;
		wbData = '0;
		allocValid = 1'b0;
		allocReg = '0;
		repeat (resetCycles) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		checkValue("idle_o", 1, idle);
		checkValue("reqValid_o", 0, reqValid);
		// Every register starts ready with random contents
		for (int r = 0; r < agenPkg::numPhysRegs; r++) begin
			writeBack(r, $random(seed));
		end
		for (int n = 0; n < numOps; n++) begin
			runOperation();
		end
		repeat (3) @(negedge clk);
		assert (expAddr.size() == 0) else begin
			otherErrors++;
			$display("Some issued operations never produced a request");
		end
		assertErrors = agenTop_inst.agenChecker_inst.failCount;
		$display("Errors: %0d value, %0d protocol, %0d assertion",
			valueErrors, otherErrors, assertErrors);
		if (valueErrors + otherErrors + assertErrors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(timeoutCycles * clkPeriod);
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verification/agenChecker.sv ====
`timescale 1ns/1ps

module agenChecker (
	input logic                   clk,
	input logic                   rst,
	input logic                   gatherDone_i,
	input logic                   reqValid_i,
	input logic                   idle_i,
	input agenPkg::stationState_t state_i
);

	int failCount = 0;

	// ========================================
	// Result timing
	// ========================================

	// The address unit registers the request, so valid trails gatherDone by one edge
	reqFollowsDone: assert property (
		@(posedge clk) disable iff (rst) reqValid_i == $past(gatherDone_i)
	) else begin
		failCount++;
		$error("reqValid_o does not follow gatherDone by exactly one cycle");
	end

	// A request is a single pulse with no back-pressure to stretch it
	reqSinglePulse: assert property (
		@(posedge clk) disable iff (rst) reqValid_i |=> !reqValid_i
	) else begin
		failCount++;
		$error("reqValid_o stayed high for two cycles");
	end

	// While operands are still being gathered the station must not fall back to idle
	// Only the gatherDone cycle may hand the station back
	idleNotInGather: assert property (
		@(posedge clk) disable iff (rst)
		(state_i == agenPkg::ST_GATHER && !gatherDone_i) |=> !idle_i
	) else begin
		failCount++;
		$error("idle_o rose before the station finished gathering");
	end

endmodule

// ==== design/agenTop.sv ====
`timescale 1ns/1ps

module agenTop (
	input  logic                              clk,
	input  logic                              rst,
	// Issue group
	input  logic                              issue_i,
	input  agenPkg::memOp_t                   issueOp_i,
	input  logic [agenPkg::robIndexWidth-1:0] issueRobIndex_i,
	input  logic [agenPkg::pRegWidth-1:0]     issuePRs1_i,
	input  logic [agenPkg::pRegWidth-1:0]     issuePRs2_i,
	input  logic [agenPkg::pRegWidth-1:0]     issuePRs3_i,
	input  logic [agenPkg::immWidth-1:0]      issueImm_i,
	// Writeback group
	input  logic                              wbValid_i,
	input  logic [agenPkg::pRegWidth-1:0]     wbReg_i,
	input  logic [agenPkg::dataWidth-1:0]     wbData_i,
	// Allocation group
	input  logic                              allocValid_i,
	input  logic [agenPkg::pRegWidth-1:0]     allocReg_i,
	output logic                              idle_o,
	// Result group
	output logic                              reqValid_o,
	output agenPkg::memOp_t                   reqOp_o,
	output logic [agenPkg::robIndexWidth-1:0] reqRobIndex_o,
	output logic [agenPkg::dataWidth-1:0]     reqAddr_o,
	output logic [agenPkg::dataWidth-1:0]     reqData_o
);

	// Lanes from the register file into the station
	logic [agenPkg::pRegWidth-1:0] laneReg   [agenPkg::numLanes];
	logic                          laneValid [agenPkg::numLanes];
	logic [agenPkg::dataWidth-1:0] laneData  [agenPkg::numLanes];

	// Source numbers the station asks the register file for
	logic [agenPkg::pRegWidth-1:0] srcReg0;
	logic [agenPkg::pRegWidth-1:0] srcReg1;
	logic [agenPkg::pRegWidth-1:0] srcReg2;

	// Station to address unit
	logic                              gatherDone;
	agenPkg::memOp_t                   opCode;
	logic [agenPkg::robIndexWidth-1:0] robIndex;
	logic [agenPkg::dataWidth-1:0]     argA;
	logic [agenPkg::dataWidth-1:0]     argB;
	logic [agenPkg::dataWidth-1:0]     argC;
	logic [agenPkg::immWidth-1:0]      argI;

	physRegFile physRegFile_inst (
		.clk          (clk),
		.rst          (rst),
		.wbValid_i    (wbValid_i),
		.wbReg_i      (wbReg_i),
		.wbData_i     (wbData_i),
		.allocValid_i (allocValid_i),
		.allocReg_i   (allocReg_i),
		.srcReg0_i    (srcReg0),
		.srcReg1_i    (srcReg1),
		.srcReg2_i    (srcReg2),
		.laneReg_o    (laneReg),
		.laneValid_o  (laneValid),
		.laneData_o   (laneData)
	);

	agenStation agenStation_inst (
		.clk             (clk),
		.rst             (rst),
		.issue_i         (issue_i),
		.issueOp_i       (issueOp_i),
		.issueRobIndex_i (issueRobIndex_i),
		.issuePRs1_i     (issuePRs1_i),
		.issuePRs2_i     (issuePRs2_i),
		.issuePRs3_i     (issuePRs3_i),
		.issueImm_i      (issueImm_i),
		.laneReg_i       (laneReg),
		.laneValid_i     (laneValid),
		.laneData_i      (laneData),
		.srcReg0_o       (srcReg0),
		.srcReg1_o       (srcReg1),
		.srcReg2_o       (srcReg2),
		.idle_o          (idle_o),
		.gatherDone_o    (gatherDone),
		.opCode_o        (opCode),
		.robIndex_o      (robIndex),
		.argA_o          (argA),
		.argB_o          (argB),
		.argC_o          (argC),
		.argI_o          (argI)
	);

	addressCalc addressCalc_inst (
		.clk           (clk),
		.rst           (rst),
		.gatherDone_i  (gatherDone),
		.opCode_i      (opCode),
		.robIndex_i    (robIndex),
		.argA_i        (argA),
		.argB_i        (argB),
		.argC_i        (argC),
		.argI_i        (argI),
		.reqValid_o    (reqValid_o),
		.reqOp_o       (reqOp_o),
		.reqRobIndex_o (reqRobIndex_o),
		.reqAddr_o     (reqAddr_o),
		.reqData_o     (reqData_o)
	);

endmodule

// ==== design/addressCalc.sv ====
`timescale 1ns/1ps

module addressCalc (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              gatherDone_i,
	input  agenPkg::memOp_t                   opCode_i,
	input  logic [agenPkg::robIndexWidth-1:0] robIndex_i,
	input  logic [agenPkg::dataWidth-1:0]     argA_i,
	input  logic [agenPkg::dataWidth-1:0]     argB_i,
	input  logic [agenPkg::dataWidth-1:0]     argC_i,
	input  logic [agenPkg::immWidth-1:0]      argI_i,
	// Finished memory request
	output logic                              reqValid_o,
	output agenPkg::memOp_t                   reqOp_o,
	output logic [agenPkg::robIndexWidth-1:0] reqRobIndex_o,
	output logic [agenPkg::dataWidth-1:0]     reqAddr_o,
	output logic [agenPkg::dataWidth-1:0]     reqData_o
);

	logic [agenPkg::dataWidth-1:0] immExt;
	logic [agenPkg::dataWidth-1:0] addrSum;
	logic [agenPkg::dataWidth-1:0] addrNext;
	logic [agenPkg::dataWidth-1:0] dataNext;

	// Effective address is base plus index plus the sign-extended immediate
	assign immExt = {{(agenPkg::dataWidth - agenPkg::immWidth){argI_i[agenPkg::immWidth-1]}},
		argI_i};
	assign addrSum = argA_i + argB_i + immExt;

	// Only stores and atomics carry data
	// A NOP still goes out so its reorder buffer entry can complete
	always_comb begin
		case (opCode_i)
			agenPkg::MEM_LOAD: begin
				addrNext = addrSum;
				dataNext = '0;
			end
			agenPkg::MEM_STORE, agenPkg::MEM_AMO: begin
				addrNext = addrSum;
				dataNext = argC_i;
			end
			default: begin
				addrNext = '0;
				dataNext = '0;
			end
		endcase
	end

	// The valid pulse tracks gatherDone one cycle later
	always_ff @(posedge clk) begin
		if (rst) begin
			reqValid_o <= 1'b0;
		end else begin
			reqValid_o <= gatherDone_i;
		end
	end

	always_ff @(posedge clk) begin
		if (gatherDone_i) begin
			reqOp_o <= opCode_i;
			reqRobIndex_o <= robIndex_i;
			reqAddr_o <= addrNext;
			reqData_o <= dataNext;
		end
	end

endmodule

// ==== design/agenStation.sv ====
`timescale 1ns/1ps

module agenStation (
	input  logic                              clk,
	input  logic                              rst,
	// Issue port from the reorder buffer
	input  logic                              issue_i,
	input  agenPkg::memOp_t                   issueOp_i,
	input  logic [agenPkg::robIndexWidth-1:0] issueRobIndex_i,
	input  logic [agenPkg::pRegWidth-1:0]     issuePRs1_i,
	input  logic [agenPkg::pRegWidth-1:0]     issuePRs2_i,
	input  logic [agenPkg::pRegWidth-1:0]     issuePRs3_i,
	input  logic [agenPkg::immWidth-1:0]      issueImm_i,
	// Broadcast lanes from the register file
	input  logic [agenPkg::pRegWidth-1:0]     laneReg_i   [agenPkg::numLanes],
	input  logic                              laneValid_i [agenPkg::numLanes],
	input  logic [agenPkg::dataWidth-1:0]     laneData_i  [agenPkg::numLanes],
	// Captured source numbers, read back through lanes 0 to 2
	output logic [agenPkg::pRegWidth-1:0]     srcReg0_o,
	output logic [agenPkg::pRegWidth-1:0]     srcReg1_o,
	output logic [agenPkg::pRegWidth-1:0]     srcReg2_o,
	output logic                              idle_o,
	// Toward the address unit
	output logic                              gatherDone_o,
	output agenPkg::memOp_t                   opCode_o,
	output logic [agenPkg::robIndexWidth-1:0] robIndex_o,
	output logic [agenPkg::dataWidth-1:0]     argA_o,
	output logic [agenPkg::dataWidth-1:0]     argB_o,
	output logic [agenPkg::dataWidth-1:0]     argC_o,
	output logic [agenPkg::immWidth-1:0]      argI_o
);

	agenPkg::stationState_t state;

	// Captured instruction fields
	agenPkg::memOp_t opCode;
	logic [agenPkg::robIndexWidth-1:0] robIndex;
	logic [agenPkg::immWidth-1:0] argImm;
	logic [agenPkg::pRegWidth-1:0] srcReg [3];

	// Operand slots, index 0 is base, 1 is index and 2 is store data
	logic [2:0] argValid;
	logic [2:0] argValidNext;
	logic [agenPkg::dataWidth-1:0] argVal [3];
	logic [agenPkg::dataWidth-1:0] argValNext [3];

	// ========================================
	// Operand match
	// ========================================

	// Looks for one source across all lanes and keeps the first valid hit
	// An operand already held is left alone, and register zero reads as zero
	function automatic void matchOperand(
		input  logic [agenPkg::pRegWidth-1:0] src,
		input  logic                          curValid,
		input  logic [agenPkg::dataWidth-1:0] curVal,
		output logic                          nextValid,
		output logic [agenPkg::dataWidth-1:0] nextVal
	);
		nextValid = curValid;
		nextVal = curVal;
		if (!curValid) begin
			if (src == '0) begin
				nextValid = 1'b1;
				nextVal = '0;
			end else begin
				for (int lane = 0; lane < agenPkg::numLanes; lane++) begin
					// Once a hit is taken, later lanes are ignored
					if (!nextValid && laneValid_i[lane] && laneReg_i[lane] == src) begin
						nextValid = 1'b1;
						nextVal = laneData_i[lane];
					end
				end
			end
		end
	endfunction

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			matchOperand(srcReg[i], argValid[i], argVal[i], argValidNext[i], argValNext[i]);
		end
	end

	// ========================================
	// Control
	// ========================================

	// Issue is only taken while idle, and it clears all three valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= agenPkg::ST_IDLE;
			argValid <= '0;
		end else begin
			case (state)
				agenPkg::ST_IDLE: begin
					if (issue_i) begin
						state <= agenPkg::ST_GATHER;
						argValid <= '0;
					end
				end
				agenPkg::ST_GATHER: begin
					argValid <= argValidNext;
					// This is the gatherDone cycle, so go back to idle
					if (&argValid) begin
						state <= agenPkg::ST_IDLE;
					end
				end
				default: state <= agenPkg::ST_IDLE;
			endcase
		end
	end

	// Instruction payload and operand values
	always_ff @(posedge clk) begin
		if (state == agenPkg::ST_IDLE && issue_i) begin
			opCode <= issueOp_i;
			robIndex <= issueRobIndex_i;
			argImm <= issueImm_i;
			srcReg[0] <= issuePRs1_i;
			srcReg[1] <= issuePRs2_i;
			srcReg[2] <= issuePRs3_i;
		end
		if (state == agenPkg::ST_GATHER) begin
			for (int i = 0; i < 3; i++) begin
				argVal[i] <= argValNext[i];
			end
		end
	end

	assign idle_o = (state == agenPkg::ST_IDLE);
	// High for the single cycle in which every operand is in hand
	assign gatherDone_o = (state == agenPkg::ST_GATHER) && (&argValid);

	assign srcReg0_o = srcReg[0];
	assign srcReg1_o = srcReg[1];
	assign srcReg2_o = srcReg[2];
	assign opCode_o = opCode;
	assign robIndex_o = robIndex;
	assign argA_o = argVal[0];
	assign argB_o = argVal[1];
	assign argC_o = argVal[2];
	assign argI_o = argImm;

endmodule

// ==== design/physRegFile.sv ====
`timescale 1ns/1ps

module physRegFile (
	input  logic                           clk,
	input  logic                           rst,
	// Writeback from the execution units
	input  logic                           wbValid_i,
	input  logic [agenPkg::pRegWidth-1:0]  wbReg_i,
	input  logic [agenPkg::dataWidth-1:0]  wbData_i,
	// Allocation of a freshly renamed destination register
	input  logic                           allocValid_i,
	input  logic [agenPkg::pRegWidth-1:0]  allocReg_i,
	// Source numbers the station is waiting on
	input  logic [agenPkg::pRegWidth-1:0]  srcReg0_i,
	input  logic [agenPkg::pRegWidth-1:0]  srcReg1_i,
	input  logic [agenPkg::pRegWidth-1:0]  srcReg2_i,
	// Broadcast lanes toward the station
	output logic [agenPkg::pRegWidth-1:0]  laneReg_o   [agenPkg::numLanes],
	output logic                           laneValid_o [agenPkg::numLanes],
	output logic [agenPkg::dataWidth-1:0]  laneData_o  [agenPkg::numLanes]
);

	// Register values, written only by writeback
	logic [agenPkg::dataWidth-1:0] regValue [agenPkg::numPhysRegs];

	// One ready bit per physical register
	logic [agenPkg::numPhysRegs-1:0] ready;

	// The three read ports, gathered into an array so the lanes loop cleanly
	logic [agenPkg::pRegWidth-1:0] srcReg [agenPkg::numLanes-1];

	assign srcReg[0] = srcReg0_i;
	assign srcReg[1] = srcReg1_i;
	assign srcReg[2] = srcReg2_i;

	// ========================================
	// Storage and scoreboard
	// ========================================

	always_ff @(posedge clk) begin
		if (wbValid_i) begin
			regValue[wbReg_i] <= wbData_i;
		end
	end

	// Allocation clears a ready bit and writeback sets it
	// Writeback is applied last, so it wins when both name the same register
	// Register zero is never renamed, so its bit is held set
	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= '0;
			ready[0] <= 1'b1;
		end else begin
			if (allocValid_i) begin
				ready[allocReg_i] <= 1'b0;
			end
			if (wbValid_i) begin
				ready[wbReg_i] <= 1'b1;
			end
			ready[0] <= 1'b1;
		end
	end

	// ========================================
	// Lane broadcast
	// ========================================

	always_comb begin
		// Read lanes present the stored value once the register is ready
		for (int lane = 0; lane < agenPkg::numLanes - 1; lane++) begin
			laneReg_o[lane] = srcReg[lane];
			laneValid_o[lane] = ready[srcReg[lane]];
			laneData_o[lane] = regValue[srcReg[lane]];
		end
		// The last lane forwards this cycle's writeback straight through
		laneReg_o[agenPkg::numLanes-1] = wbReg_i;
		laneValid_o[agenPkg::numLanes-1] = wbValid_i;
		laneData_o[agenPkg::numLanes-1] = wbData_i;
	end

endmodule

// ==== design/agenPkg.sv ====
// ========================================
// Shared widths and sizes
// ========================================

package agenPkg;

	// Width of a register value and of an effective address
	localparam int dataWidth = 32;

	// Number of physical registers behind the rename map
	localparam int numPhysRegs = 64;

	// Width of a physical register number, enough to index numPhysRegs
	localparam int pRegWidth = 6;

	// Width of a reorder buffer index, one entry per in-flight instruction
	localparam int robIndexWidth = 5;

	// The immediate arrives narrow and is sign-extended in the address unit
	localparam int immWidth = 12;

	// Lanes 0 to 2 carry the register file reads for the three sources
	// and lane 3 carries the writeback of the current cycle as a bypass
	localparam int numLanes = 4;

	// ========================================
	// Encodings
	// ========================================

	// Memory operation codes carried from issue through to the request
	typedef enum logic [1:0] {
		MEM_NOP   = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2,
		MEM_AMO   = 2'd3
	} memOp_t;

	// Station states
	// The station sits in ST_IDLE until an issue and then gathers operands
	typedef enum logic {
		ST_IDLE   = 1'b0,
		ST_GATHER = 1'b1
	} stationState_t;

endpackage
